// File: hw/stage_fifo_pkg.sv
// Shared sizes, latency and width types of the staged FIFO
// Modules reference these by scoped name, for example stage_fifo_pkg::data_t
package stage_fifo_pkg;

  // ====================
  // Sizes
  // ====================

  // Width of one stored word
  localparam int DATA_W = 16;

  // Total capacity in items, staged items included
  localparam int FIFO_DEPTH = 16;

  // RAM address width, enough to index FIFO_DEPTH entries
  localparam int ADDR_W = 4;

  // Total count must reach FIFO_DEPTH itself, hence one extra bit
  localparam int COUNT_W = 5;

  // Cycles from a read request to its data valid
  localparam int RAM_RD_LATENCY = 2;

  // One cell per read in flight plus one so that reads can stream at full rate
  localparam int BUF_DEPTH = RAM_RD_LATENCY + 1;

  // Staged count runs from 0 to BUF_DEPTH
  localparam int BUF_COUNT_W = 2;

  // ====================
  // Types
  // ====================

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [COUNT_W-1:0] count_t;
  typedef logic [BUF_COUNT_W-1:0] buf_count_t;

  // Onehot pointer over the staging cells, bit i selects cell i
  typedef logic [BUF_DEPTH-1:0] buf_onehot_t;

endpackage

// File: hw/fifo_push_ctrl.sv
// Push side of the staged FIFO
// Accepts writes into the RAM and keeps the total number of items held
module fifo_push_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,

  // External push port
  input  logic                   push_valid,
  output logic                   push_ready,
  input  stage_fifo_pkg::data_t  push_data,

  // Pop beat from the staging buffer, one item leaves the FIFO
  input  logic                   pop_beat,

  // RAM write port
  output logic                   wr_en,
  output stage_fifo_pkg::addr_t  wr_addr,
  output stage_fifo_pkg::data_t  wr_data,

  // Items in the FIFO, RAM and staging buffer together
  output stage_fifo_pkg::count_t total_items
);

  // ====================
  // Handshake
  // ====================

  logic                  push_beat;
  stage_fifo_pkg::addr_t wr_ptr;

  // Ready comes from the registered count only, so it never looks at
  // push_valid or at the pop side in the same cycle
  assign push_ready = total_items < stage_fifo_pkg::count_t'(stage_fifo_pkg::FIFO_DEPTH);
  assign push_beat  = push_valid && push_ready;

  // Every accepted word goes straight into the RAM at the tail
  assign wr_en   = push_beat;
  assign wr_addr = wr_ptr;
  assign wr_data = push_data;

  // ====================
  // Write address
  // ====================

  // Tail pointer, wraps after the last RAM entry
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (push_beat) begin
      if (wr_ptr == stage_fifo_pkg::addr_t'(stage_fifo_pkg::FIFO_DEPTH - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // ====================
  // Item count
  // ====================

  // Up on a push beat, down on a pop beat
  // When both happen together the count holds
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      total_items <= '0;
    end else begin
      case ({push_beat, pop_beat})
        2'b10: begin
          total_items <= total_items + 1'b1;
        end
        2'b01: begin
          total_items <= total_items - 1'b1;
        end
        default: begin
          total_items <= total_items;
        end
      endcase
    end
  end

endmodule

// File: hw/fifo_ram.sv
// Register-array storage for the staged FIFO with a fixed read latency
// Read data and its valid come out RAM_RD_LATENCY cycles after rd_req
module fifo_ram (
  input  logic                  clk,
  input  logic                  rst_n,

  // Write port from the push controller
  input  logic                  wr_en,
  input  stage_fifo_pkg::addr_t wr_addr,
  input  stage_fifo_pkg::data_t wr_data,

  // Read port from the staging buffer, no back-pressure
  input  logic                  rd_req,
  input  stage_fifo_pkg::addr_t rd_addr,
  output logic                  rd_data_valid,
  output stage_fifo_pkg::data_t rd_data
);

  // ====================
  // Storage
  // ====================

  stage_fifo_pkg::data_t mem [stage_fifo_pkg::FIFO_DEPTH];

  // Read pipeline, stage 0 holds the word sampled on the request edge
  logic                  rd_valid_q [stage_fifo_pkg::RAM_RD_LATENCY];
  stage_fifo_pkg::data_t rd_data_q  [stage_fifo_pkg::RAM_RD_LATENCY];

  // Write and read never hit the same entry in one cycle
  // since a push is only accepted while an entry is free
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ====================
  // Read pipeline
  // ====================

  // Valid bits need reset so nothing comes out before the first read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < stage_fifo_pkg::RAM_RD_LATENCY; i++) begin
        rd_valid_q[i] <= 1'b0;
      end
    end else begin
      rd_valid_q[0] <= rd_req;
      for (int i = 1; i < stage_fifo_pkg::RAM_RD_LATENCY; i++) begin
        rd_valid_q[i] <= rd_valid_q[i-1];
      end
    end
  end

  // Payload stages run freely, every stage moves each cycle
  // so several reads can be in flight at once
  always_ff @(posedge clk) begin
    rd_data_q[0] <= mem[rd_addr];
    for (int i = 1; i < stage_fifo_pkg::RAM_RD_LATENCY; i++) begin
      rd_data_q[i] <= rd_data_q[i-1];
    end
  end

  // Last stage is the read result
  assign rd_data_valid = rd_valid_q[stage_fifo_pkg::RAM_RD_LATENCY-1];
  assign rd_data       = rd_data_q[stage_fifo_pkg::RAM_RD_LATENCY-1];

endmodule

// File: hw/fifo_staging_buffer.sv
// Pop-side staging buffer of the staged FIFO
// Prefetches from the RAM into a small onehot circular buffer and drives the pop port
module fifo_staging_buffer (
  input  logic                   clk,
  input  logic                   rst_n,

  // Items held in the whole FIFO, from the push controller
  input  stage_fifo_pkg::count_t total_items,

  // RAM read port
  output logic                   rd_req,
  output stage_fifo_pkg::addr_t  rd_addr,
  input  logic                   rd_data_valid,
  input  stage_fifo_pkg::data_t  rd_data,

  // External pop port
  output logic                   pop_valid,
  input  logic                   pop_ready,
  output stage_fifo_pkg::data_t  pop_data,

  // One item leaves the FIFO this cycle
  output logic                   pop_beat
);

  // ====================
  // Read issue
  // ====================

  // Reads in flight plus items stored here
  stage_fifo_pkg::buf_count_t staged_items;

  // Room for one more read, either a free cell or a cell freed by this pop
  logic space_available;

  // Some items still sit in the RAM with no read issued for them
  logic items_not_staged;

  assign pop_beat = pop_valid && pop_ready;

  assign space_available =
      (staged_items < stage_fifo_pkg::buf_count_t'(stage_fifo_pkg::BUF_DEPTH)) || pop_ready;
  assign items_not_staged = stage_fifo_pkg::count_t'(staged_items) < total_items;

  // A read is only issued with guaranteed room, so returned data is never dropped
  assign rd_req = space_available && items_not_staged;

  // Staged count goes up on each read issued and down on each pop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      staged_items <= '0;
    end else begin
      case ({rd_req, pop_beat})
        2'b10: begin
          staged_items <= staged_items + 1'b1;
        end
        2'b01: begin
          staged_items <= staged_items - 1'b1;
        end
        default: begin
          staged_items <= staged_items;
        end
      endcase
    end
  end

  // Head address in the RAM, wraps like the write pointer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr <= '0;
    end else if (rd_req) begin
      if (rd_addr == stage_fifo_pkg::addr_t'(stage_fifo_pkg::FIFO_DEPTH - 1)) begin
        rd_addr <= '0;
      end else begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

  // ====================
  // Circular buffer
  // ====================

  stage_fifo_pkg::data_t       mem [stage_fifo_pkg::BUF_DEPTH];
  stage_fifo_pkg::data_t       mem_rd_data;
  stage_fifo_pkg::buf_onehot_t rd_ptr_onehot;
  stage_fifo_pkg::buf_onehot_t wr_ptr_onehot;
  logic                        maybe_full;
  logic                        ptr_match;
  logic                        empty;
  logic                        advance_wr_ptr;
  logic                        advance_rd_ptr;

  // Equal pointers mean either empty or full, maybe_full tells which
  assign ptr_match = rd_ptr_onehot == wr_ptr_onehot;
  assign empty     = ptr_match && !maybe_full;

  // Returned data is stored unless it can go straight out on the pop port
  assign advance_wr_ptr = rd_data_valid && !(empty && pop_ready);

  // Head only moves when a stored item is popped
  // A forwarded word never touched the buffer
  assign advance_rd_ptr = !empty && pop_ready;

  // Pointers start on cell 0 and rotate left by one cell per advance
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_onehot <= stage_fifo_pkg::buf_onehot_t'(1);
      rd_ptr_onehot <= stage_fifo_pkg::buf_onehot_t'(1);
    end else begin
      if (advance_wr_ptr) begin
        wr_ptr_onehot <= {wr_ptr_onehot[stage_fifo_pkg::BUF_DEPTH-2:0],
                          wr_ptr_onehot[stage_fifo_pkg::BUF_DEPTH-1]};
      end
      if (advance_rd_ptr) begin
        rd_ptr_onehot <= {rd_ptr_onehot[stage_fifo_pkg::BUF_DEPTH-2:0],
                          rd_ptr_onehot[stage_fifo_pkg::BUF_DEPTH-1]};
      end
    end
  end

  // Set by a write without a read, cleared by a read without a write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      maybe_full <= 1'b0;
    end else if (advance_wr_ptr != advance_rd_ptr) begin
      maybe_full <= advance_wr_ptr;
    end
  end

  // Only the cell under the write pointer loads
  always_ff @(posedge clk) begin
    for (int i = 0; i < stage_fifo_pkg::BUF_DEPTH; i++) begin
      if (advance_wr_ptr && wr_ptr_onehot[i]) begin
        mem[i] <= rd_data;
      end
    end
  end

  // AND-OR mux on the onehot head pointer, no decoder needed
  always_comb begin
    mem_rd_data = '0;
    for (int i = 0; i < stage_fifo_pkg::BUF_DEPTH; i++) begin
      mem_rd_data = mem_rd_data | (mem[i] & {stage_fifo_pkg::DATA_W{rd_ptr_onehot[i]}});
    end
  end

  // ====================
  // Pop port
  // ====================

  // With the buffer empty the RAM word is forwarded in the cycle it returns
  // If the consumer stalls, that word is stored and shows up again from the head
  assign pop_valid = !empty || rd_data_valid;
  assign pop_data  = empty ? rd_data : mem_rd_data;

endmodule

// File: hw/stage_fifo.sv
// Top level of the staged FIFO with push and pop valid/ready ports
// Joins the push controller, the latency RAM and the pop-side staging buffer
module stage_fifo (
  input  logic                  clk,
  input  logic                  rst_n,

  // Push port
  input  logic                  push_valid,
  output logic                  push_ready,
  input  stage_fifo_pkg::data_t push_data,

  // Pop port
  output logic                  pop_valid,
  input  logic                  pop_ready,
  output stage_fifo_pkg::data_t pop_data
);

  // RAM write side
  logic                   wr_en;
  stage_fifo_pkg::addr_t  wr_addr;
  stage_fifo_pkg::data_t  wr_data;

  // RAM read side
  logic                   rd_req;
  stage_fifo_pkg::addr_t  rd_addr;
  logic                   rd_data_valid;
  stage_fifo_pkg::data_t  rd_data;

  // Count exchange between the two ends
  logic                   pop_beat;
  stage_fifo_pkg::count_t total_items;

  fifo_push_ctrl u_push_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_valid  (push_valid),
    .push_ready  (push_ready),
    .push_data   (push_data),
    .pop_beat    (pop_beat),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .total_items (total_items)
  );

  fifo_ram u_ram (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .rd_req        (rd_req),
    .rd_addr       (rd_addr),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data)
  );

  fifo_staging_buffer u_staging (
    .clk           (clk),
    .rst_n         (rst_n),
    .total_items   (total_items),
    .rd_req        (rd_req),
    .rd_addr       (rd_addr),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data),
    .pop_valid     (pop_valid),
    .pop_ready     (pop_ready),
    .pop_data      (pop_data),
    .pop_beat      (pop_beat)
  );

endmodule

// File: tb/tb_clock_gen.sv
// Free-running clock for the staged FIFO testbench
// Period is 4 time units, the first rising edge comes at time 2
module tb_clock_gen (
  output logic clk
);

  // Half of the clock period
  localparam int HALF_PERIOD = 2;

  // Starts low so that the first edge is a rising one
  initial begin
    clk = 1'b0;
    forever begin
      #HALF_PERIOD clk = ~clk;
    end
  end

endmodule

// File: tb/stage_fifo_tb.sv
// Self-checking testbench for the staged FIFO, applies a phase table to both ports
// Every accepted push enters a queue model that each pop is compared against
module stage_fifo_tb;

  // ====================
  // Run settings
  // ====================

  localparam int NUM_PHASES    = 6;
  localparam int RESET_CYCLES  = 10;
  localparam int PUSH_TIMEOUT  = 200;
  localparam int DRAIN_TIMEOUT = 200;
  localparam int HOLD_CYCLES   = 8;

  // Push edge to pop_valid, one cycle for the count register and then the RAM read
  localparam int POP_LATENCY = 1 + stage_fifo_pkg::RAM_RD_LATENCY;

  // Patterns for pop_ready during the push part of a phase
  localparam logic [1:0] POP_ALWAYS = 2'd0;
  localparam logic [1:0] POP_NEVER  = 2'd1;
  localparam logic [1:0] POP_RANDOM = 2'd2;

  // Stimulus table with one row per phase
  // Row 0 is the single-word latency case, the NEVER rows fill the FIFO to capacity
  localparam int PHASE_WORDS [NUM_PHASES] = '{
    1, stage_fifo_pkg::FIFO_DEPTH, 5, 400, stage_fifo_pkg::FIFO_DEPTH, 300
  };
  localparam stage_fifo_pkg::data_t PHASE_BASE [NUM_PHASES] = '{
    16'h1000, 16'h2000, 16'h3000, 16'h4000, 16'h5000, 16'h6000
  };
  localparam logic [1:0] PHASE_MODE [NUM_PHASES] = '{
    POP_ALWAYS, POP_NEVER, POP_ALWAYS, POP_RANDOM, POP_NEVER, POP_RANDOM
  };

  // ====================
  // DUT and clock
  // ====================

  logic                  clk;
  logic                  rst_n;
  logic                  push_valid;
  logic                  push_ready;
  stage_fifo_pkg::data_t push_data;
  logic                  pop_valid;
  logic                  pop_ready;
  stage_fifo_pkg::data_t pop_data;

  // Words accepted and not yet popped, head first
  stage_fifo_pkg::data_t model_q [$];

  logic [31:0] rng_state = 32'h53be58d2;
  int          cycle_count = 0;
  int          first_push_cycle = -1;
  int          first_pop_cycle = -1;
  logic        push_taken = 1'b0;
  logic        pop_stalled = 1'b0;

  tb_clock_gen u_clock_gen (
    .clk (clk)
  );

  stage_fifo u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_data  (push_data),
    .pop_valid  (pop_valid),
    .pop_ready  (pop_ready),
    .pop_data   (pop_data)
  );

  // ====================
  // Helpers
  // ====================

  // Xorshift32 step, also used for random handshakes
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic abort_test(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_test($sformatf("error %s: got 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  // One clock cycle, inputs change on the rising edge and outputs are read on the falling one
  // Beats seen at the falling edge happen on the next rising edge
  task automatic run_cycle(input logic drive_push, input stage_fifo_pkg::data_t word,
                           input logic drive_pop);
    @(posedge clk);
    push_valid <= drive_push;
    push_data  <= word;
    pop_ready  <= drive_pop;
    @(negedge clk);
    cycle_count++;
    // Ready follows the item count, which the model holds before this cycle's beats
    check_value("push_ready", 32'(push_ready),
                32'(model_q.size() < stage_fifo_pkg::FIFO_DEPTH));
    // A stalled word must still be on offer
    if (pop_stalled) begin
      check_value("pop_valid", 32'(pop_valid), 32'd1);
    end
    if (pop_valid && model_q.size() == 0) begin
      abort_test("pop_valid is high while the model holds no word");
    end else if (pop_valid) begin
      check_value("pop_data", 32'(pop_data), 32'(model_q[0]));
      if (first_pop_cycle < 0) begin
        first_pop_cycle = cycle_count;
      end
      if (pop_ready) begin
        void'(model_q.pop_front());
      end
    end
    pop_stalled = pop_valid && !pop_ready;
    // Pushes enter the tail after any pop of this cycle
    push_taken = push_valid && push_ready;
    if (push_taken) begin
      model_q.push_back(push_data);
      if (first_push_cycle < 0) begin
        first_push_cycle = cycle_count;
      end
    end
  endtask

  // Pops until the model is empty and pop_valid has dropped
  task automatic drain_fifo(input int idx);
    int waited;
    waited = 0;
    while (model_q.size() != 0 || pop_valid) begin
      if (waited >= DRAIN_TIMEOUT) begin
        abort_test($sformatf("timeout while draining the FIFO in phase %0d", idx));
      end else begin
        run_cycle(1'b0, '0, 1'b1);
        waited++;
      end
    end
    check_value("push_ready", 32'(push_ready), 32'd1);
  endtask

  // Pushes one table row, holds a full FIFO if the row never pops, then drains
  task automatic apply_phase(input int idx);
    int                    sent;
    int                    waited;
    logic [31:0]           r;
    logic                  drive_push;
    logic                  drive_pop;
    stage_fifo_pkg::data_t word;
    sent = 0;
    waited = 0;
    first_push_cycle = -1;
    first_pop_cycle = -1;
    r = next_random();
    word = PHASE_BASE[idx] | stage_fifo_pkg::data_t'(r[11:0]);
    while (sent < PHASE_WORDS[idx]) begin
      if (waited >= PUSH_TIMEOUT) begin
        abort_test($sformatf("timeout waiting for push %0d of phase %0d", sent, idx));
      end else begin
        r = next_random();
        drive_push = (PHASE_MODE[idx] == POP_RANDOM) ? r[0] : 1'b1;
        case (PHASE_MODE[idx])
          POP_ALWAYS: drive_pop = 1'b1;
          POP_NEVER:  drive_pop = 1'b0;
          default:    drive_pop = r[1];
        endcase
        run_cycle(drive_push, word, drive_pop);
        // The word stays on push_data until it is taken
        if (push_taken) begin
          sent++;
          waited = 0;
          r = next_random();
          word = PHASE_BASE[idx] | stage_fifo_pkg::data_t'(r[11:0]);
        end else begin
          waited++;
        end
      end
    end
    // A full FIFO keeps refusing pushes and keeps its head on the pop port
    if (PHASE_MODE[idx] == POP_NEVER) begin
      for (int i = 0; i < HOLD_CYCLES; i++) begin
        run_cycle(1'b1, word, 1'b0);
        check_value("push_ready", 32'(push_ready), 32'd0);
      end
    end
    drain_fifo(idx);
    // Each phase starts empty, so its first word shows the full read latency
    check_value("pop_valid latency", 32'(first_pop_cycle - first_push_cycle),
                32'(POP_LATENCY));
  endtask

  // ====================
  // Main sequence
  // ====================

  initial begin
    push_valid = 1'b0;
    push_data  = '0;
    pop_ready  = 1'b0;
    rst_n      = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("push_ready", 32'(push_ready), 32'd1);
    check_value("pop_valid", 32'(pop_valid), 32'd0);
    for (int i = 0; i < NUM_PHASES; i++) begin
      apply_phase(i);
    end
    $display("all tests passed");
    $finish;
  end

endmodule

// File: stage_fifo.f
hw/stage_fifo_pkg.sv
hw/fifo_push_ctrl.sv
hw/fifo_ram.sv
hw/fifo_staging_buffer.sv
hw/stage_fifo.sv
tb/tb_clock_gen.sv
tb/stage_fifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the staged FIFO testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

LOG_FILE=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing -Wno-fatal \
  --top-module stage_fifo_tb \
  --Mdir "$OBJ_DIR" \
  -o stage_fifo_sim \
  -f stage_fifo.f

# The log decides the result, a stopped run never prints the pass line
"./$OBJ_DIR/stage_fifo_sim" 2>&1 | tee "$LOG_FILE"

if grep -q "all tests passed" "$LOG_FILE"; then
  echo "simulation PASSED"
  exit 0
else
  echo "simulation FAILED"
  exit 1
fi
